// ==== Makefile ====
# Verilator build for the acquisition buffer

TOP = aq_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f aq_top.f

sim:
	verilator --binary --timing --top-module $(TOP) -f aq_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== aq_top.f ====
design/aq_pkg.sv
design/sample_fifo.sv
design/block_buffer.sv
design/block_word_counter.sv
design/aq_fifo_ctl.sv
design/tx_fifo_ctl.sv
design/aq_top.sv
tests/aq_top_tb.sv

// ==== design/aq_fifo_ctl.sv ====
// acquisition control
// gates sample writes and moves 32-word blocks from the acquisition FIFO to the block buffer
`default_nettype none

module aq_fifo_ctl
(
   input  logic             write_clk,
   input  logic             rst,
   input  logic             start_aq,
   input  aq_pkg::level_t   aq_level,
   input  logic             last_word,
   output logic             aq_rd,
   output logic             cnt_count,
   output logic             cnt_clear,
   output logic             bb_wr,
   output aq_pkg::bb_addr_t bb_wr_addr,
   output logic             acquiring,
   output logic             bb_filled
);

   aq_pkg::aq_state_t state;
   aq_pkg::bb_addr_t  wr_ptr;
   logic              rd_delay;     // FIFO read data lands one cycle after aq_rd
   logic              block_ready;
   logic              last_block;

   assign block_ready = aq_level >= aq_pkg::level_t'(aq_pkg::BLOCKSIZE);

   // two writes of the block are still pending when the last read issues
   assign last_block = wr_ptr == aq_pkg::bb_addr_t'(aq_pkg::FILL_THRESHOLD - 2);

   assign aq_rd     = state == aq_pkg::AQ_READING;
   assign cnt_count = aq_rd;
   assign cnt_clear = (state == aq_pkg::AQ_WRITING) && block_ready;

   assign bb_wr      = rd_delay;
   assign bb_wr_addr = wr_ptr;

   // samples keep flowing in while a block is moved
   assign acquiring = (state == aq_pkg::AQ_WRITING) || (state == aq_pkg::AQ_READING);
   assign bb_filled = state == aq_pkg::AQ_FINISHED;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
         state <= aq_pkg::AQ_WAITING;
      else
      begin
         case (state)
            aq_pkg::AQ_WAITING:
            begin
               if (start_aq)
                  state <= aq_pkg::AQ_WRITING;
            end
            aq_pkg::AQ_WRITING:
            begin
               if (block_ready)
                  state <= aq_pkg::AQ_READING;
            end
            aq_pkg::AQ_READING:
            begin
               if (last_word)
               begin
                  if (last_block)
                     state <= aq_pkg::AQ_FINISHED;
                  else
                     state <= aq_pkg::AQ_WRITING;
               end
            end
            aq_pkg::AQ_FINISHED:
               state <= aq_pkg::AQ_FINISHED;  // held until reset
            default:
               state <= aq_pkg::AQ_WAITING;
         endcase
      end
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         rd_delay <= 1'b0;
         wr_ptr   <= '0;
      end
      else
      begin
         rd_delay <= aq_rd;
         if (rd_delay)
            wr_ptr <= wr_ptr + aq_pkg::bb_addr_t'(1);
      end
   end

endmodule

`default_nettype wire

// ==== design/aq_pkg.sv ====
// acquisition buffer package
// word widths, buffer sizes, transmit thresholds and controller state encodings
`default_nettype none

package aq_pkg;

   localparam int SAMPLE_WIDTH   = 16;
   localparam int BB_ADDR_WIDTH  = 9;
   localparam int LEVEL_WIDTH    = 7;  // holds 0..64
   localparam int WORD_CNT_WIDTH = 5;

   typedef logic [SAMPLE_WIDTH-1:0]   sample_t;
   typedef logic [BB_ADDR_WIDTH-1:0]  bb_addr_t;
   typedef logic [LEVEL_WIDTH-1:0]    level_t;
   typedef logic [WORD_CNT_WIDTH-1:0] word_cnt_t;

   localparam int BLOCKSIZE      = 32;   // words per block move
   localparam int BB_DEPTH       = 512;
   localparam int FILL_THRESHOLD = BB_DEPTH - BLOCKSIZE;

   localparam int AQ_FIFO_DEPTH  = 64;
   localparam int TX_FIFO_DEPTH  = 32;

   // transmit refill hysteresis
   localparam int TX_HIGH_MARK   = 16;
   localparam int TX_LOW_MARK    = 5;

   typedef enum logic [1:0]
   {
      AQ_WAITING,
      AQ_WRITING,
      AQ_READING,
      AQ_FINISHED
   } aq_state_t;

   typedef enum logic [1:0]
   {
      TX_WAITING,
      TX_FILLING,
      TX_IDLE,
      TX_DONE
   } tx_state_t;

endpackage

`default_nettype wire

// ==== design/aq_top.sv ====
// acquisition buffer top level
// acquisition FIFO, block buffer and transmit FIFO with their two controllers
`default_nettype none

module aq_top
(
   input  logic            write_clk,
   input  logic            rst,
   input  logic            start_aq,
   input  logic            sample_valid,
   input  aq_pkg::sample_t sample_data,
   input  logic            tx_rd,
   output logic            acquiring,
   output logic            bb_filled,
   output aq_pkg::sample_t tx_data,
   output logic            tx_empty,
   output aq_pkg::level_t  tx_level,
   output logic            tx_done
);

   logic             aq_wr;
   logic             aq_rd;
   aq_pkg::sample_t  aq_rd_data;
   aq_pkg::level_t   aq_level;
   logic             last_word;
   logic             cnt_count;
   logic             cnt_clear;
   logic             bb_wr;
   aq_pkg::bb_addr_t bb_wr_addr;
   aq_pkg::bb_addr_t bb_rd_addr;
   aq_pkg::sample_t  bb_rd_data;
   logic             tx_wr;

   assign aq_wr = sample_valid && acquiring;  // nothing is taken outside acquisition

   sample_fifo #(.DEPTH(aq_pkg::AQ_FIFO_DEPTH)) aq_fifo_i
   (
      .write_clk (write_clk),
      .rst       (rst),
      .wr        (aq_wr),
      .wr_data   (sample_data),
      .rd        (aq_rd),
      .rd_data   (aq_rd_data),
      .level     (aq_level),
      .empty     (),
      .full      ()
   );

   block_word_counter block_word_counter_i
   (
      .write_clk (write_clk),
      .rst       (rst),
      .clear     (cnt_clear),
      .count     (cnt_count),
      .last_word (last_word)
   );

   aq_fifo_ctl aq_fifo_ctl_i
   (
      .write_clk  (write_clk),
      .rst        (rst),
      .start_aq   (start_aq),
      .aq_level   (aq_level),
      .last_word  (last_word),
      .aq_rd      (aq_rd),
      .cnt_count  (cnt_count),
      .cnt_clear  (cnt_clear),
      .bb_wr      (bb_wr),
      .bb_wr_addr (bb_wr_addr),
      .acquiring  (acquiring),
      .bb_filled  (bb_filled)
   );

   block_buffer block_buffer_i
   (
      .write_clk (write_clk),
      .wr        (bb_wr),
      .wr_addr   (bb_wr_addr),
      .wr_data   (aq_rd_data),
      .rd_addr   (bb_rd_addr),
      .rd_data   (bb_rd_data)
   );

   tx_fifo_ctl tx_fifo_ctl_i
   (
      .write_clk  (write_clk),
      .rst        (rst),
      .bb_filled  (bb_filled),
      .tx_level   (tx_level),
      .bb_rd_addr (bb_rd_addr),
      .tx_wr      (tx_wr),
      .tx_done    (tx_done)
   );

   sample_fifo #(.DEPTH(aq_pkg::TX_FIFO_DEPTH)) tx_fifo_i
   (
      .write_clk (write_clk),
      .rst       (rst),
      .wr        (tx_wr),
      .wr_data   (bb_rd_data),
      .rd        (tx_rd),
      .rd_data   (tx_data),
      .level     (tx_level),
      .empty     (tx_empty),
      .full      ()
   );

endmodule

`default_nettype wire

// ==== design/block_buffer.sv ====
// block buffer
// 512-word simple dual-port memory, one write port and one registered read port
`default_nettype none

module block_buffer
(
   input  logic             write_clk,
   input  logic             wr,
   input  aq_pkg::bb_addr_t wr_addr,
   input  aq_pkg::sample_t  wr_data,
   input  aq_pkg::bb_addr_t rd_addr,
   output aq_pkg::sample_t  rd_data
);

   aq_pkg::sample_t mem [aq_pkg::BB_DEPTH];

   always_ff @(posedge write_clk)
   begin
      if (wr)
         mem[wr_addr] <= wr_data;
   end

   // read data follows the address by one cycle
   always_ff @(posedge write_clk)
   begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== design/block_word_counter.sv ====
// block word counter
// tracks the word index inside one block move and flags the last word
`default_nettype none

module block_word_counter
(
   input  logic write_clk,
   input  logic rst,
   input  logic clear,
   input  logic count,
   output logic last_word
);

   aq_pkg::word_cnt_t word_cnt;

   assign last_word = word_cnt == aq_pkg::word_cnt_t'(aq_pkg::BLOCKSIZE - 1);

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
         word_cnt <= '0;
      else if (clear)
         word_cnt <= '0;
      else if (count)
      begin
         if (last_word)
            word_cnt <= '0;  // block complete
         else
            word_cnt <= word_cnt + aq_pkg::word_cnt_t'(1);
      end
   end

endmodule

`default_nettype wire

// ==== design/sample_fifo.sv ====
// sample FIFO
// circular buffer with registered read data and a fill level
`default_nettype none

module sample_fifo
#(
   parameter int DEPTH = 64
)
(
   input  logic            write_clk,
   input  logic            rst,
   input  logic            wr,
   input  aq_pkg::sample_t wr_data,
   input  logic            rd,
   output aq_pkg::sample_t rd_data,
   output aq_pkg::level_t  level,
   output logic            empty,
   output logic            full
);

   localparam int PTR_W = $clog2(DEPTH);

   aq_pkg::sample_t  mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             wr_ok;
   logic             rd_ok;

   assign full  = level == aq_pkg::level_t'(DEPTH);
   assign empty = level == '0;

   // overflow and underflow attempts are simply dropped
   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_ok, rd_ok})
            2'b10:   level <= level + aq_pkg::level_t'(1);
            2'b01:   level <= level - aq_pkg::level_t'(1);
            default: level <= level;
         endcase
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wr_data;
   end

   // read word shows up the cycle after rd
   always_ff @(posedge write_clk)
   begin
      if (rd_ok)
         rd_data <= mem[rd_ptr];
   end

endmodule

`default_nettype wire

// ==== design/tx_fifo_ctl.sv ====
// transmit control
// streams the filled block buffer region into the transmit FIFO with hysteresis
`default_nettype none

module tx_fifo_ctl
(
   input  logic             write_clk,
   input  logic             rst,
   input  logic             bb_filled,
   input  aq_pkg::level_t   tx_level,
   output aq_pkg::bb_addr_t bb_rd_addr,
   output logic             tx_wr,
   output logic             tx_done
);

   aq_pkg::tx_state_t state;
   aq_pkg::bb_addr_t  rd_ptr;
   aq_pkg::level_t    projected;   // level once the in-flight write lands
   logic              all_issued;
   logic              at_high;
   logic              issue;

   assign projected  = tx_level + aq_pkg::level_t'(tx_wr);
   assign at_high    = projected >= aq_pkg::level_t'(aq_pkg::TX_HIGH_MARK);
   assign all_issued = rd_ptr == aq_pkg::bb_addr_t'(aq_pkg::FILL_THRESHOLD);

   // one buffer read per cycle while filling and below the high mark
   assign issue = (state == aq_pkg::TX_FILLING) && !all_issued && !at_high;

   assign bb_rd_addr = rd_ptr;
   assign tx_done    = state == aq_pkg::TX_DONE;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= aq_pkg::TX_WAITING;
         rd_ptr <= '0;
         tx_wr  <= 1'b0;
      end
      else
      begin
         tx_wr <= issue;  // buffer data is valid a cycle after the address
         if (issue)
            rd_ptr <= rd_ptr + aq_pkg::bb_addr_t'(1);
         case (state)
            aq_pkg::TX_WAITING:
            begin
               if (bb_filled)
                  state <= aq_pkg::TX_FILLING;
            end
            aq_pkg::TX_FILLING:
            begin
               if (all_issued)
                  state <= aq_pkg::TX_DONE;  // last write lands on this edge
               else if (at_high)
                  state <= aq_pkg::TX_IDLE;
            end
            aq_pkg::TX_IDLE:
            begin
               if (tx_level < aq_pkg::level_t'(aq_pkg::TX_LOW_MARK))
                  state <= aq_pkg::TX_FILLING;
            end
            aq_pkg::TX_DONE:
               state <= aq_pkg::TX_DONE;
            default:
               state <= aq_pkg::TX_WAITING;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== tests/aq_top_tb.sv ====
// acquisition buffer testbench
// directed tests for sample gating, block acquisition, transmit hysteresis and drain order
`default_nettype none

module aq_top_tb;

   timeunit 1ns;
   timeprecision 100ps;

   logic            write_clk = 1'b0;
   logic            rst;
   logic            start_aq;
   logic            sample_valid;
   aq_pkg::sample_t sample_data;
   logic            tx_rd;
   logic            acquiring;
   logic            bb_filled;
   aq_pkg::sample_t tx_data;
   logic            tx_empty;
   aq_pkg::level_t  tx_level;
   logic            tx_done;

   logic [31:0]     lfsr_state;
   aq_pkg::sample_t sent_q[$];     // samples offered while acquiring
   int              rd_idx;        // next expected output word
   int              error_count;
   int              timeout_count;

   always #20 write_clk = ~write_clk;

   aq_top aq_top_i
   (
      .write_clk    (write_clk),
      .rst          (rst),
      .start_aq     (start_aq),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .tx_rd        (tx_rd),
      .acquiring    (acquiring),
      .bb_filled    (bb_filled),
      .tx_data      (tx_data),
      .tx_empty     (tx_empty),
      .tx_level     (tx_level),
      .tx_done      (tx_done)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] val);
      val = '0;
      repeat (n)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[14:0], lfsr_state[0]};  // one step per bit
      end
   endtask

   task automatic check_sample(input string what, input aq_pkg::sample_t got,
                               input aq_pkg::sample_t exp);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input string what, input aq_pkg::level_t got,
                              input aq_pkg::level_t exp);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeout_count++;
      $display("timed out at %0t ns while waiting for %s", $time, what);
   endtask

   // one strobe, data checked on the next falling edge
   task automatic read_word();
      tx_rd = 1'b1;
      @(negedge write_clk);
      tx_rd = 1'b0;
      if (rd_idx < sent_q.size())
         check_sample("tx_data", tx_data, sent_q[rd_idx]);
      else
         check_sample("tx_data beyond sent samples", tx_data, 'x);
      rd_idx++;
   endtask

   task automatic verify_reset_state();
      check_flag("acquiring", acquiring, 1'b0);
      check_flag("bb_filled", bb_filled, 1'b0);
      check_flag("tx_done", tx_done, 1'b0);
      check_flag("tx_empty", tx_empty, 1'b1);
      check_level("tx_level", tx_level, '0);
   endtask

   task automatic reject_before_start();
      logic [15:0] bits;
      repeat (6)
      begin
         take_bits(16, bits);
         sample_data  = bits;
         sample_valid = 1'b1;
         @(negedge write_clk);
         check_flag("acquiring before start", acquiring, 1'b0);
      end
      sample_valid = 1'b0;
   endtask

   task automatic acquire_blocks();
      logic [15:0] bits;
      int          cycles;
      cycles   = 0;
      start_aq = 1'b1;
      while (!bb_filled && cycles < 2000)
      begin
         sample_valid = acquiring;
         if (acquiring)
         begin
            take_bits(16, bits);
            sample_data = bits;
            sent_q.push_back(bits);
         end
         @(negedge write_clk);
         cycles++;
      end
      if (!bb_filled)
         report_timeout("bb_filled");
      check_flag("acquiring after fill", acquiring, 1'b0);
      repeat (8)
      begin
         take_bits(16, bits);
         sample_data  = bits;     // not queued, must be dropped
         sample_valid = 1'b1;
         @(negedge write_clk);
         check_flag("acquiring after fill", acquiring, 1'b0);
      end
      sample_valid = 1'b0;
   endtask

   task automatic hold_at_high_mark();
      int cycles;
      cycles = 0;
      while (tx_level != aq_pkg::level_t'(aq_pkg::TX_HIGH_MARK) && cycles < 200)
      begin
         @(negedge write_clk);
         cycles++;
      end
      if (tx_level != aq_pkg::level_t'(aq_pkg::TX_HIGH_MARK))
         report_timeout("tx_level to reach the high mark");
      repeat (20)
      begin
         @(negedge write_clk);
         check_level("tx_level with reader stalled", tx_level,
                     aq_pkg::level_t'(aq_pkg::TX_HIGH_MARK));
         check_flag("tx_done", tx_done, 1'b0);
      end
      cycles = 0;
      while (tx_level > aq_pkg::level_t'(aq_pkg::TX_LOW_MARK - 1) && cycles < 100)
      begin
         read_word();
         cycles++;
      end
      check_level("tx_level after reads", tx_level, aq_pkg::level_t'(aq_pkg::TX_LOW_MARK - 1));
      cycles = 0;
      while (tx_level <= aq_pkg::level_t'(aq_pkg::TX_LOW_MARK - 1) && cycles < 50)
      begin
         @(negedge write_clk);
         cycles++;
      end
      if (tx_level <= aq_pkg::level_t'(aq_pkg::TX_LOW_MARK - 1))
         report_timeout("refill below the low mark");
   endtask

   task automatic drain_and_finish();
      logic [15:0] bits;
      int          cycles;
      int          gap;
      cycles = 0;
      while (rd_idx < aq_pkg::FILL_THRESHOLD && cycles < 20000)
      begin
         take_bits(2, bits);
         gap = int'(bits);   // 0 to 3 stalled cycles
         repeat (gap) @(negedge write_clk);
         if (tx_empty)
            @(negedge write_clk);
         else
            read_word();
         cycles += gap + 1;
      end
      if (rd_idx < aq_pkg::FILL_THRESHOLD)
         report_timeout("all 480 words on tx_data");
      cycles = 0;
      while (!tx_done && cycles < 100)
      begin
         @(negedge write_clk);
         cycles++;
      end
      if (!tx_done)
         report_timeout("tx_done");
      check_flag("tx_empty at end", tx_empty, 1'b1);
      tx_rd = 1'b1;   // reads of an empty FIFO
      repeat (4) @(negedge write_clk);
      tx_rd = 1'b0;
      check_level("tx_level after extra reads", tx_level, '0);
      check_flag("tx_empty after extra reads", tx_empty, 1'b1);
      check_flag("tx_done at end", tx_done, 1'b1);
   endtask

   initial
   begin
      rst           = 1'b1;
      start_aq      = 1'b0;
      sample_valid  = 1'b0;
      sample_data   = '0;
      tx_rd         = 1'b0;
      lfsr_state    = 32'ha2e2;
      rd_idx        = 0;
      error_count   = 0;
      timeout_count = 0;
      repeat (2) @(posedge write_clk);
      @(negedge write_clk);
      rst = 1'b0;
      verify_reset_state();
      reject_before_start();
      acquire_blocks();
      hold_at_high_mark();
      drain_and_finish();
      $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire
